// ==== tb/video_patterns.hex ====
// kind[31:28] addr or h[27:16] data or v[15:0], kind f ends the list
// 1/2 char/scroll write, 3/4 read expect, b/c read in a cen6 cycle
// 5 scroll pos, 6 flip, 7 enables char/scr, 8 lhbl/lvbl, 9 probe
1022005A
14220047
1085003C
148500C2
10CA0077
14CA0001
20530011
24530005
20730022
24730083
20130033
2413000E
3022005A
B4220047
40530011
C4530005
80000003
60000000
70000002
9013000A
902C0021
70000001
50000000
90500030
50000025
90500030
5000012C
90F00030
50000000
70000003
90500030
2453000D
90500030
60000001
91AF00CF
60000000
80000001
90500030
80000002
90500030
80000003
F0000000

// ==== build.f ====
+incdir+tb
src/video_pkg.sv
src/cpu_bus_pkg.sv
src/char_layer.sv
src/scroll_layer.sv
src/color_mixer.sv
src/video_top.sv
tb/video_checker.sv
tb/video_tb.sv

// ==== Bender.yml ====
package:
  name: video_bg

sources:
  - files:
      - src/video_pkg.sv
      - src/cpu_bus_pkg.sv
      - src/char_layer.sv
      - src/scroll_layer.sv
      - src/color_mixer.sv
      - src/video_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/video_checker.sv
      - tb/video_tb.sv

// ==== tb/rom_hash.svh ====
//////////////////////////////
// tile ROM contents
//  Galois LFSR step
//  address hash for both ROMs
//////////////////////////////

localparam logic [31:0] hash_seed = 32'h8f43_6dc9;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // taps 32, 30, 26, 25
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
endfunction

// one LFSR step per data bit, bit 0 first
function automatic logic [23:0] rom_hash(input logic [15:0] addr, input int nbits);
    logic [31:0] s;
    logic [23:0] r;
    s = hash_seed ^ {addr, ~addr};
    r = '0;
    for (int i = 0; i < nbits; i++) begin
        s = lfsr_step(s);
        r[i] = s[0];
    end
    return r;
endfunction

// ==== tb/video_tb.sv ====
`timescale 1ns/100ps
//////////////////////////////
// video path testbench
//  clock, cen6 and reset
//  tile ROM models
//  pattern file driven cpu and
//  probe stimulus, watchdog
//////////////////////////////

module video_tb;

    `include "rom_hash.svh"

    logic        clk;
    logic        rst;
    logic        cen6;
    logic [10:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic        rnw;
    logic        flip;
    logic [8:0]  h;
    logic [7:0]  v;
    logic        char_cs;
    logic        scr_cs;
    logic        scrpos_cs;
    logic        blue_cs;
    logic        redgreen_cs;
    logic        enable_char;
    logic        enable_scr;
    logic        lhbl;
    logic        lvbl;
    logic [7:0]  chram_dout;
    logic [7:0]  scram_dout;
    logic        char_mrdy;
    logic        scr_mrdy;
    logic [12:0] char_addr;
    logic [14:0] scr_addr;
    logic [15:0] chrom_data;
    logic [23:0] scrom_data;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        probe;
    logic [7:0]  exp_data;
    int          checks;
    int          errors;

    // record layout is kind in [31:28] with address or h in [27:16] and data or v in [15:0]
    logic [31:0] patterns [0:63];
    int          n_rec;
    logic [31:0] pal_state;

    video_top dut (.*);
    video_checker u_check (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cen6 <= rst ? 1'b0 : ~cen6;

    always_comb chrom_data = 16'(rom_hash({3'b000, char_addr}, 16));
    always_comb scrom_data = rom_hash({1'b0, scr_addr}, 24);

    // align puts the select into a cen6 cycle
    task automatic layer_access(input int sel, input logic [10:0] addr,
                                input logic [7:0] data, input logic rd, input logic align);
        @(posedge clk);
        while (cen6 !== !align)
            @(posedge clk);
        cpu_addr <= addr;
        cpu_dout <= data;
        exp_data <= data;
        rnw      <= rd;
        if (sel == 0)
            char_cs <= 1'b1;
        else
            scr_cs <= 1'b1;
        do
            @(posedge clk);
        while (!(sel == 0 ? char_mrdy : scr_mrdy));
        char_cs <= 1'b0;
        scr_cs  <= 1'b0;
        rnw     <= 1'b1;
    endtask

    // palette and scroll registers take the write on the first edge
    task automatic reg_write(input int sel, input logic [10:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_addr    <= addr;
        cpu_dout    <= data;
        rnw         <= 1'b0;
        redgreen_cs <= (sel == 0);
        blue_cs     <= (sel == 1);
        scrpos_cs   <= (sel == 2);
        @(posedge clk);
        redgreen_cs <= 1'b0;
        blue_cs     <= 1'b0;
        scrpos_cs   <= 1'b0;
        rnw         <= 1'b1;
    endtask

    task automatic pixel_probe(input logic [8:0] hp, input logic [7:0] vp);
        @(posedge clk);
        h <= hp;
        v <= vp;
        // let the pipeline fill with this position
        repeat ((video_pkg::pixel_latency + 1) * 2) @(posedge clk);
        probe <= 1'b1;
        @(posedge clk);
        probe <= 1'b0;
    endtask

    function automatic logic [7:0] next_pal_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            pal_state = lfsr_step(pal_state);
            b[i] = pal_state[0];
        end
        return b;
    endfunction

    task automatic run_record(input logic [31:0] r);
        case (r[31:28])
            4'h1: layer_access(0, r[26:16], r[7:0], 1'b0, 1'b0);
            4'h2: layer_access(1, r[26:16], r[7:0], 1'b0, 1'b0);
            4'h3: layer_access(0, r[26:16], r[7:0], 1'b1, 1'b0);
            4'h4: layer_access(1, r[26:16], r[7:0], 1'b1, 1'b0);
            4'hb: layer_access(0, r[26:16], r[7:0], 1'b1, 1'b1);
            4'hc: layer_access(1, r[26:16], r[7:0], 1'b1, 1'b1);
            4'h5: begin
                reg_write(2, 11'd0, r[7:0]);
                reg_write(2, 11'd1, {7'd0, r[8]});
            end
            4'h6: flip <= r[0];
            4'h7: begin
                enable_char <= r[1];
                enable_scr  <= r[0];
            end
            4'h8: begin
                lhbl <= r[1];
                lvbl <= r[0];
            end
            4'h9: pixel_probe(r[24:16], r[7:0]);
            default: $display("unknown record kind %h", r[31:28]);
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cen6        = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        rnw         = 1'b1;
        flip        = 1'b0;
        h           = '0;
        v           = '0;
        char_cs     = 1'b0;
        scr_cs      = 1'b0;
        scrpos_cs   = 1'b0;
        blue_cs     = 1'b0;
        redgreen_cs = 1'b0;
        enable_char = 1'b1;
        enable_scr  = 1'b1;
        lhbl        = 1'b1;
        lvbl        = 1'b1;
        probe       = 1'b0;
        exp_data    = '0;
        pal_state   = hash_seed;
        for (int i = 0; i < 64; i++)
            patterns[i] = 32'hf000_0000;
        $readmemh("tb/video_patterns.hex", patterns);
        n_rec = 0;
        while (n_rec < 64 && patterns[n_rec][31:28] != 4'hf)
            n_rec++;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // every palette entry gets a value
        for (int i = 0; i < 256; i++) begin
            reg_write(0, 11'(i), next_pal_byte());
            reg_write(1, 11'(i), next_pal_byte());
        end
        for (int i = 0; i < n_rec; i++)
            run_record(patterns[i]);
        repeat (4) @(posedge clk);
        $display("tests run %0d, failed %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : watchdog
        @(posedge clk);
        repeat (n_rec * 64 + 1000) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== tb/video_checker.sv ====
`timescale 1ns/100ps
//////////////////////////////
// video path checker
//  shadow layer RAMs and palette
//  cpu access and read checks
//  pixel prediction at probes
//////////////////////////////

module video_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen6,
    input  logic [10:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        rnw,
    input  logic        char_cs,
    input  logic        scr_cs,
    input  logic        scrpos_cs,
    input  logic        blue_cs,
    input  logic        redgreen_cs,
    input  logic        char_mrdy,
    input  logic        scr_mrdy,
    input  logic [7:0]  chram_dout,
    input  logic [7:0]  scram_dout,
    input  logic [12:0] char_addr,
    input  logic [14:0] scr_addr,
    input  logic        flip,
    input  logic [8:0]  h,
    input  logic [7:0]  v,
    input  logic        enable_char,
    input  logic        enable_scr,
    input  logic        lhbl,
    input  logic        lvbl,
    input  logic [3:0]  red,
    input  logic [3:0]  green,
    input  logic [3:0]  blue,
    input  logic        probe,
    input  logic [7:0]  exp_data,
    output int          checks,
    output int          errors
);

    `include "rom_hash.svh"

    logic [7:0] char_ram [0:2047];
    logic [7:0] scr_ram  [0:2047];
    logic [7:0] rg_ram   [0:255];
    logic [3:0] b_ram    [0:255];
    logic [8:0] scrpos;
    logic       prev_rst = 1'b1;

    // per layer access state indexed 0 for char and 1 for scroll
    bit         in_acc    [2];
    bit         first_cen [2];
    int         stalls    [2];
    bit         rd_pend   [2];
    logic [7:0] rd_exp    [2];

    initial begin
        checks = 0;
        errors = 0;
    end

    function automatic bit compare_value(input string name, input logic [31:0] exp,
                                         input logic [31:0] act);
        if (exp !== act)
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        return exp === act;
    endfunction

    task automatic report_test(input bit ok, input string what);
        checks++;
        if (!ok)
            errors++;
        $display("%s: %s", what, ok ? "ok" : "failed");
    endtask

    function automatic logic [11:0] predict_rgb();
        logic [8:0]        hf;
        logic [8:0]        hs;
        logic [7:0]        vf;
        logic [9:0]        ci;
        logic [9:0]        si;
        logic [7:0]        cattr;
        logic [7:0]        sattr;
        logic [23:0]       cd;
        logic [23:0]       sd;
        logic [1:0]        cc;
        logic [2:0]        sc;
        logic [7:0]        idx;
        video_pkg::layer_e win;
        hf = flip ? ~h : h;
        vf = flip ? ~v : v;
        ci = {vf[7:3], hf[7:3]};
        cattr = char_ram[{1'b1, ci}];
        cd = rom_hash({3'b000, cattr[7:6], char_ram[{1'b0, ci}], vf[2:0]}, 16);
        cc = cd[15 - 2*hf[2:0] -: 2];
        hs = hf + scrpos;
        si = {1'b0, hs[8:4], vf[7:4]};
        sattr = scr_ram[{1'b1, si}];
        sd = rom_hash({1'b0, sattr[7:6], scr_ram[{1'b0, si}], vf[3:0], hs[3]}, 24);
        sc = sd[23 - 3*hs[2:0] -: 3];
        if (enable_scr && sc != 0 && (sattr[3] || !enable_char || cc == 0))
            win = video_pkg::layer_scroll;
        else if (enable_char && cc != 0)
            win = video_pkg::layer_char;
        else
            win = video_pkg::layer_none;
        case (win)
            video_pkg::layer_char:   idx = {2'b11, cattr[3:0], cc};
            video_pkg::layer_scroll: idx = {2'b00, sattr[2:0], sc};
            default:                 idx = 8'd0;
        endcase
        if (!(lhbl && lvbl))
            return 12'd0;
        return {rg_ram[idx], b_ram[idx]};
    endfunction

    task automatic track_access(input int l, input logic cs, input logic mrdy,
                                input logic [7:0] dout);
        bit ok;
        if (rd_pend[l]) begin
            rd_pend[l] = 0;
            ok = compare_value(l == 0 ? "chram_dout" : "scram_dout", rd_exp[l], dout);
            report_test(ok, l == 0 ? "char RAM read" : "scroll RAM read");
        end
        if (cs && !rst) begin
            if (!in_acc[l]) begin
                in_acc[l]    = 1;
                first_cen[l] = cen6;
                stalls[l]    = 0;
            end
            if (!mrdy) begin
                stalls[l]++;
            end else begin
                in_acc[l] = 0;
                // one wait cycle only when the access opened in a cen6 cycle
                ok = (stalls[l] == int'(first_cen[l]));
                if (!ok)
                    $display("ready was low for %0d cycles on layer %0d at %0t",
                             stalls[l], l, $time);
                report_test(ok, l == 0 ? "char ready handshake" : "scroll ready handshake");
                if (rnw) begin
                    rd_pend[l] = 1;
                    rd_exp[l]  = exp_data;
                end else if (l == 0) begin
                    char_ram[cpu_addr] = cpu_dout;
                end else begin
                    scr_ram[cpu_addr] = cpu_dout;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        logic [11:0] exp_rgb;
        bit          ok;
        if (prev_rst && !rst) begin
            ok = compare_value("char_mrdy", 1, char_mrdy);
            ok = compare_value("scr_mrdy", 1, scr_mrdy) && ok;
            ok = compare_value("red", 0, red) && ok;
            ok = compare_value("green", 0, green) && ok;
            ok = compare_value("blue", 0, blue) && ok;
            ok = compare_value("char_addr", 0, char_addr) && ok;
            ok = compare_value("scr_addr", 0, scr_addr) && ok;
            report_test(ok, "state after reset");
        end
        prev_rst = rst;
        track_access(0, char_cs, char_mrdy, chram_dout);
        track_access(1, scr_cs, scr_mrdy, scram_dout);
        if (redgreen_cs)
            rg_ram[cpu_addr[7:0]] = cpu_dout;
        if (blue_cs)
            b_ram[cpu_addr[7:0]] = cpu_dout[3:0];
        if (rst)
            scrpos = '0;
        else if (scrpos_cs && !rnw && cpu_addr[0])
            scrpos[8] = cpu_dout[0];
        else if (scrpos_cs && !rnw)
            scrpos[7:0] = cpu_dout;
        if (probe) begin
            exp_rgb = predict_rgb();
            ok = compare_value("red", exp_rgb[11:8], red);
            ok = compare_value("green", exp_rgb[7:4], green) && ok;
            ok = compare_value("blue", exp_rgb[3:0], blue) && ok;
            report_test(ok, $sformatf("pixel h=%h v=%h", h, v));
        end
    end

endmodule

// ==== src/video_top.sv ====
`timescale 1ns/100ps
//////////////////////////////
// background video path
//  character and scroll layers
//  feeding the colour mixer
//////////////////////////////

module video_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cen6,
    input  logic [cpu_bus_pkg::cpu_addr_bits-1:0] cpu_addr,
    input  logic [cpu_bus_pkg::cpu_data_bits-1:0] cpu_dout,
    input  logic                                  rnw,
    input  logic                                  flip,
    input  logic [video_pkg::h_width-1:0]         h,
    input  logic [video_pkg::v_width-1:0]         v,
    // char layer
    input  logic                                  char_cs,
    output logic [cpu_bus_pkg::cpu_data_bits-1:0] chram_dout,
    output logic                                  char_mrdy,
    output logic [12:0]                           char_addr,
    input  logic [15:0]                           chrom_data,
    // scroll layer
    input  logic                                  scr_cs,
    input  logic                                  scrpos_cs,
    output logic [cpu_bus_pkg::cpu_data_bits-1:0] scram_dout,
    output logic                                  scr_mrdy,
    output logic [14:0]                           scr_addr,
    input  logic [23:0]                           scrom_data,
    // mixer
    input  logic                                  blue_cs,
    input  logic                                  redgreen_cs,
    input  logic                                  enable_char,
    input  logic                                  enable_scr,
    input  logic                                  lhbl,
    input  logic                                  lvbl,
    output logic [video_pkg::rgb_bits-1:0]        red,
    output logic [video_pkg::rgb_bits-1:0]        green,
    output logic [video_pkg::rgb_bits-1:0]        blue
);

    logic [video_pkg::char_col_bits-1:0] char_col;
    logic [video_pkg::char_pal_bits-1:0] char_pal;
    logic [video_pkg::scr_col_bits-1:0]  scr_col;
    logic [video_pkg::scr_pal_bits-1:0]  scr_pal;
    logic                                scr_prio;

    char_layer u_char (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen6       ( cen6       ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .rnw        ( rnw        ),
        .char_cs    ( char_cs    ),
        .flip       ( flip       ),
        .h          ( h          ),
        .v          ( v          ),
        .chrom_data ( chrom_data ),
        .chram_dout ( chram_dout ),
        .char_mrdy  ( char_mrdy  ),
        .char_addr  ( char_addr  ),
        .char_col   ( char_col   ),
        .char_pal   ( char_pal   )
    );

    scroll_layer u_scroll (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen6       ( cen6       ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .rnw        ( rnw        ),
        .scr_cs     ( scr_cs     ),
        .scrpos_cs  ( scrpos_cs  ),
        .flip       ( flip       ),
        .h          ( h          ),
        .v          ( v          ),
        .scrom_data ( scrom_data ),
        .scram_dout ( scram_dout ),
        .scr_mrdy   ( scr_mrdy   ),
        .scr_addr   ( scr_addr   ),
        .scr_col    ( scr_col    ),
        .scr_pal    ( scr_pal    ),
        .scr_prio   ( scr_prio   )
    );

    // palette sees only the low address byte
    color_mixer u_colmix (
        .clk         ( clk           ),
        .rst         ( rst           ),
        .cen6        ( cen6          ),
        .cpu_addr    ( cpu_addr[7:0] ),
        .cpu_dout    ( cpu_dout      ),
        .blue_cs     ( blue_cs       ),
        .redgreen_cs ( redgreen_cs   ),
        .char_col    ( char_col      ),
        .char_pal    ( char_pal      ),
        .scr_col     ( scr_col       ),
        .scr_pal     ( scr_pal       ),
        .scr_prio    ( scr_prio      ),
        .enable_char ( enable_char   ),
        .enable_scr  ( enable_scr    ),
        .lhbl        ( lhbl          ),
        .lvbl        ( lvbl          ),
        .red         ( red           ),
        .green       ( green         ),
        .blue        ( blue          )
    );

endmodule

// ==== src/color_mixer.sv ====
`timescale 1ns/100ps
//////////////////////////////
// colour mixer
//  layer priority and transparency
//  red/green and blue palette RAMs
//  blanked, registered 4-bit rgb
//////////////////////////////

module color_mixer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cen6,
    input  logic [7:0]                          cpu_addr,
    input  logic [cpu_bus_pkg::cpu_data_bits-1:0] cpu_dout,
    input  logic                                blue_cs,
    input  logic                                redgreen_cs,
    input  logic [video_pkg::char_col_bits-1:0] char_col,
    input  logic [video_pkg::char_pal_bits-1:0] char_pal,
    input  logic [video_pkg::scr_col_bits-1:0]  scr_col,
    input  logic [video_pkg::scr_pal_bits-1:0]  scr_pal,
    input  logic                                scr_prio,
    input  logic                                enable_char,
    input  logic                                enable_scr,
    input  logic                                lhbl,
    input  logic                                lvbl,
    output logic [video_pkg::rgb_bits-1:0]      red,
    output logic [video_pkg::rgb_bits-1:0]      green,
    output logic [video_pkg::rgb_bits-1:0]      blue
);

    // red in the high nibble, green in the low one
    logic [7:0] rg_ram [0:255];
    logic [3:0] b_ram  [0:255];

    video_pkg::layer_e win;
    logic              char_opaque;
    logic              scr_opaque;
    logic [7:0]        pal_idx;

    // colour 0 and disabled layers are see-through
    assign char_opaque = enable_char && (char_col != '0);
    assign scr_opaque  = enable_scr && (scr_col != '0);

    always_comb begin
        if (scr_opaque && (scr_prio || !char_opaque))
            win = video_pkg::layer_scroll;
        else if (char_opaque)
            win = video_pkg::layer_char;
        else
            win = video_pkg::layer_none;
    end

    // chars live in the top quarter of the palette
    always_comb begin
        case (win)
            video_pkg::layer_char:   pal_idx = {2'b11, char_pal, char_col};
            video_pkg::layer_scroll: pal_idx = {2'b00, scr_pal, scr_col};
            default:                 pal_idx = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (redgreen_cs)
            rg_ram[cpu_addr] <= cpu_dout;
        if (blue_cs)
            b_ram[cpu_addr] <= cpu_dout[3:0];
    end

    // palette stage
    always_ff @(posedge clk) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (cen6) begin
            if (lhbl && lvbl) begin
                red   <= rg_ram[pal_idx][7:4];
                green <= rg_ram[pal_idx][3:0];
                blue  <= b_ram[pal_idx];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

// ==== src/scroll_layer.sv ====
`timescale 1ns/100ps
//////////////////////////////
// scroll layer
//  2 KB code/attribute RAM with cpu port
//  9-bit horizontal scroll register
//  16x16 tile fetch, 3-bit pixel,
//  palette and priority bit
//////////////////////////////

module scroll_layer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cen6,
    input  logic [cpu_bus_pkg::cpu_addr_bits-1:0] cpu_addr,
    input  logic [cpu_bus_pkg::cpu_data_bits-1:0] cpu_dout,
    input  logic                                  rnw,
    input  logic                                  scr_cs,
    input  logic                                  scrpos_cs,
    input  logic                                  flip,
    input  logic [video_pkg::h_width-1:0]         h,
    input  logic [video_pkg::v_width-1:0]         v,
    input  logic [23:0]                           scrom_data,
    output logic [cpu_bus_pkg::cpu_data_bits-1:0] scram_dout,
    output logic                                  scr_mrdy,
    output logic [14:0]                           scr_addr,
    output logic [video_pkg::scr_col_bits-1:0]    scr_col,
    output logic [video_pkg::scr_pal_bits-1:0]    scr_pal,
    output logic                                  scr_prio
);

    logic [7:0] code_ram [0:(1 << cpu_bus_pkg::attr_half)-1];
    logic [7:0] attr_ram [0:(1 << cpu_bus_pkg::attr_half)-1];

    cpu_bus_pkg::access_e                 acc;
    logic [cpu_bus_pkg::attr_half-1:0]    cpu_idx;
    logic [cpu_bus_pkg::attr_half-1:0]    scan_idx;
    logic [video_pkg::h_width-1:0]        hpos;
    logic [video_pkg::h_width-1:0]        hf;
    logic [video_pkg::h_width-1:0]        hs;
    logic [video_pkg::v_width-1:0]        vf;
    logic [video_pkg::scr_tile_bits-1:0]  tile;

    logic [7:0]                           code_q;
    logic [7:0]                           attr_q;
    logic [3:0]                           row1;
    logic                                 half1;
    logic [2:0]                           col1;
    logic [2:0]                           col2;
    logic [video_pkg::scr_pal_bits-1:0]   pal2;
    logic                                 prio2;

    assign hf = flip ? ~h : h;
    assign vf = flip ? ~v : v;

    // wraps at 512
    assign hs = hf + hpos;

    // column-major map, 32 columns of 16 rows
    assign scan_idx = {1'b0, hs[8:4], vf[7:4]};
    assign cpu_idx  = cpu_addr[cpu_bus_pkg::attr_half-1:0];
    assign tile     = {attr_q[7:6], code_q};

    assign scr_mrdy = !(scr_cs && cen6);

    always_comb begin
        if (!scr_cs || cen6)
            acc = cpu_bus_pkg::acc_idle;
        else if (rnw)
            acc = cpu_bus_pkg::acc_read;
        else
            acc = cpu_bus_pkg::acc_write;
    end

    // scroll position, high byte only keeps bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            hpos <= '0;
        end else if (scrpos_cs && !rnw) begin
            case (cpu_addr[0])
                cpu_bus_pkg::scrpos_lo: hpos[7:0] <= cpu_dout;
                cpu_bus_pkg::scrpos_hi: hpos[8]   <= cpu_dout[0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen6) begin
            code_q <= code_ram[scan_idx];
            attr_q <= attr_ram[scan_idx];
        end
        case (acc)
            cpu_bus_pkg::acc_write: begin
                if (cpu_addr[cpu_bus_pkg::attr_half])
                    attr_ram[cpu_idx] <= cpu_dout;
                else
                    code_ram[cpu_idx] <= cpu_dout;
            end
            cpu_bus_pkg::acc_read: begin
                scram_dout <= cpu_addr[cpu_bus_pkg::attr_half] ?
                              attr_ram[cpu_idx] : code_ram[cpu_idx];
            end
            default: ;
        endcase
    end

    // half picks the left or right eight pixels of the row
    always_ff @(posedge clk) begin
        if (rst)
            scr_addr <= '0;
        else if (cen6)
            scr_addr <= {tile, row1, half1};
    end

    always_ff @(posedge clk) begin
        if (cen6) begin
            row1     <= vf[3:0];
            half1    <= hs[3];
            col1     <= hs[2:0];
            col2     <= col1;
            pal2     <= attr_q[2:0];
            prio2    <= attr_q[3];
            scr_col  <= scrom_data[23 - 3*col2 -: 3];
            scr_pal  <= pal2;
            scr_prio <= prio2;
        end
    end

    a_mrdy_single : assert property (
        @(posedge clk) disable iff (rst) !scr_mrdy |=> scr_mrdy
    ) else $error("scr_mrdy low for more than one cycle");

endmodule

// ==== src/char_layer.sv ====
`timescale 1ns/100ps
//////////////////////////////
// character layer
//  2 KB code/attribute RAM with cpu port
//  8x8 tile fetch pipeline
//  2-bit pixel and palette selector
//////////////////////////////

module char_layer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cen6,
    input  logic [cpu_bus_pkg::cpu_addr_bits-1:0] cpu_addr,
    input  logic [cpu_bus_pkg::cpu_data_bits-1:0] cpu_dout,
    input  logic                                  rnw,
    input  logic                                  char_cs,
    input  logic                                  flip,
    input  logic [video_pkg::h_width-1:0]         h,
    input  logic [video_pkg::v_width-1:0]         v,
    input  logic [15:0]                           chrom_data,
    output logic [cpu_bus_pkg::cpu_data_bits-1:0] chram_dout,
    output logic                                  char_mrdy,
    output logic [12:0]                           char_addr,
    output logic [video_pkg::char_col_bits-1:0]   char_col,
    output logic [video_pkg::char_pal_bits-1:0]   char_pal
);

    logic [7:0] code_ram [0:(1 << cpu_bus_pkg::attr_half)-1];
    logic [7:0] attr_ram [0:(1 << cpu_bus_pkg::attr_half)-1];

    cpu_bus_pkg::access_e                 acc;
    logic [cpu_bus_pkg::attr_half-1:0]    cpu_idx;
    logic [cpu_bus_pkg::attr_half-1:0]    scan_idx;
    logic [video_pkg::h_width-1:0]        hf;
    logic [video_pkg::v_width-1:0]        vf;
    logic [video_pkg::char_tile_bits-1:0] tile;

    logic [7:0]                           code_q;
    logic [7:0]                           attr_q;
    logic [2:0]                           row1;
    logic [2:0]                           col1;
    logic [2:0]                           col2;
    logic [video_pkg::char_pal_bits-1:0]  pal2;

    // flip mirrors both axes
    assign hf = flip ? ~h : h;
    assign vf = flip ? ~v : v;

    assign scan_idx = {vf[7:3], hf[7:3]};
    assign cpu_idx  = cpu_addr[cpu_bus_pkg::attr_half-1:0];
    assign tile     = {attr_q[7:6], code_q};

    // fetch owns the RAM on cen6 cycles, cpu waits one clk
    assign char_mrdy = !(char_cs && cen6);

    always_comb begin
        if (!char_cs || cen6)
            acc = cpu_bus_pkg::acc_idle;
        else if (rnw)
            acc = cpu_bus_pkg::acc_read;
        else
            acc = cpu_bus_pkg::acc_write;
    end

    // single RAM port shared by fetch and cpu
    always_ff @(posedge clk) begin
        if (cen6) begin
            code_q <= code_ram[scan_idx];
            attr_q <= attr_ram[scan_idx];
        end
        case (acc)
            cpu_bus_pkg::acc_write: begin
                if (cpu_addr[cpu_bus_pkg::attr_half])
                    attr_ram[cpu_idx] <= cpu_dout;
                else
                    code_ram[cpu_idx] <= cpu_dout;
            end
            cpu_bus_pkg::acc_read: begin
                chram_dout <= cpu_addr[cpu_bus_pkg::attr_half] ?
                              attr_ram[cpu_idx] : code_ram[cpu_idx];
            end
            default: ;
        endcase
    end

    // rom address stage
    always_ff @(posedge clk) begin
        if (rst)
            char_addr <= '0;
        else if (cen6)
            char_addr <= {tile, row1};
    end

    // position and palette follow the fetch
    always_ff @(posedge clk) begin
        if (cen6) begin
            row1     <= vf[2:0];
            col1     <= hf[2:0];
            col2     <= col1;
            pal2     <= attr_q[3:0];
            // leftmost pixel sits in the top bits
            char_col <= chrom_data[15 - 2*col2 -: 2];
            char_pal <= pal2;
        end
    end

    // cen6 never lasts two clocks so the cpu stall is one cycle
    a_mrdy_single : assert property (
        @(posedge clk) disable iff (rst) !char_mrdy |=> char_mrdy
    ) else $error("char_mrdy low for more than one cycle");

endmodule

// ==== src/cpu_bus_pkg.sv ====
//////////////////////////////
// cpu bus definitions
//  address and data widths
//  layer RAM layout
//  decoded access enum
//////////////////////////////

package cpu_bus_pkg;

    localparam int cpu_addr_bits = 11;
    localparam int cpu_data_bits = 8;

    // upper half of a layer RAM holds attributes
    localparam int attr_half = 10;

    // scroll position register offsets
    localparam logic scrpos_lo = 1'b0;
    localparam logic scrpos_hi = 1'b1;

    // cpu access as seen by a RAM block
    typedef enum logic [1:0] {
        acc_idle,
        acc_read,
        acc_write
    } access_e;

endpackage

// ==== src/video_pkg.sv ====
//////////////////////////////
// video path definitions
//  screen position widths
//  tile and pixel widths per layer
//  pipeline latency and the
//  mixer layer enum
//////////////////////////////

package video_pkg;

    // screen position counters
    localparam int h_width = 9;
    localparam int v_width = 8;

    // tile code widths, code byte plus two attribute bits
    localparam int char_tile_bits = 10;
    localparam int scr_tile_bits  = 10;

    // pixel colour within a tile
    localparam int char_col_bits = 2;
    localparam int scr_col_bits  = 3;

    // palette selectors taken from the attribute byte
    localparam int char_pal_bits = 4;
    localparam int scr_pal_bits  = 3;

    // cen6 pulses from h/v to rgb
    // three layer stages and one palette stage
    localparam int pixel_latency = 4;

    localparam int rgb_bits = 4;

    // winner of a pixel at the mixer
    typedef enum logic [1:0] {
        layer_none,
        layer_char,
        layer_scroll
    } layer_e;

endpackage
